/* sources.f */
+incdir+verif
common/icache_pkg.sv
common/icache_array_if.sv
common/icache_refill_if.sv
icache/icache_sdp_ram.sv
icache/icache_arrays.sv
icache/icache_pipeline.sv
icache/icache_refill.sv
hdl/icache_top.sv
verif/tb_axi_mem.sv
verif/tb_icache.sv

/* Makefile */
TOP := tb_icache
OBJ := obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f sources.f \
		--top-module $(TOP) -Mdir $(OBJ) -o $(TOP)

run: compile
	@out="$$(./$(OBJ)/$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf $(OBJ)

/* verif/tb_mix.svh */
// beat data function shared by the testbench and its memory; every address bit reaches the word
function automatic logic [31:0] mix_word(input logic [31:0] addr);
  return (addr * 32'h9e3779b1) ^ {addr[15:0], addr[31:16]} ^ 32'h5a5a0f0f;
endfunction

/* verif/tb_icache.sv */
// self-checking icache testbench; random fetches from a small address pool plus a set conflict
`timescale 1ns/1ps

module tb_icache;
  import icache_pkg::*;

  `include "tb_mix.svh"

  localparam int N_RANDOM       = 300;
  localparam int ACCEPT_TIMEOUT = 200;
  localparam int DRAIN_TIMEOUT  = 1000;
  localparam int PATTERN [10]   = '{0, 1, 2, 0, 1, 2, 0, 0, 2, 1};

  logic        clk;
  logic        rst_n;
  logic        fetch_req_valid_i;
  logic        fetch_req_ready_o;
  addr_t       fetch_addr_i;
  logic        fetch_rsp_valid_o;
  logic        fetch_rsp_ready_i;
  addr_t       fetch_rsp_addr_o;
  word_t       fetch_rsp_instr_o;
  logic        arvalid;
  logic        arready;
  addr_t       araddr;
  logic [7:0]  arlen;
  logic [2:0]  arsize;
  logic [1:0]  arburst;
  logic        rvalid;
  logic        rready;
  word_t       rdata;
  logic        rlast;

  // reference model state
  tag_t        m_tag [SETS][WAYS];
  logic        m_valid [SETS][WAYS];
  logic        m_lru [SETS];
  addr_t       rsp_q [$];
  addr_t       ar_q [$];
  logic        expect_valid;
  logic        prev_stall;
  addr_t       prev_addr;
  word_t       prev_instr;
  int          errors;
  int          n_tests;
  int          n_rsp;
  int          n_ar;
  int          n_miss;

  icache_top icache_top_i (
    .clk               (clk),
    .rst_n             (rst_n),
    .fetch_req_valid_i (fetch_req_valid_i),
    .fetch_req_ready_o (fetch_req_ready_o),
    .fetch_addr_i      (fetch_addr_i),
    .fetch_rsp_valid_o (fetch_rsp_valid_o),
    .fetch_rsp_ready_i (fetch_rsp_ready_i),
    .fetch_rsp_addr_o  (fetch_rsp_addr_o),
    .fetch_rsp_instr_o (fetch_rsp_instr_o),
    .m_axi_arvalid_o   (arvalid),
    .m_axi_arready_i   (arready),
    .m_axi_araddr_o    (araddr),
    .m_axi_arlen_o     (arlen),
    .m_axi_arsize_o    (arsize),
    .m_axi_arburst_o   (arburst),
    .m_axi_rvalid_i    (rvalid),
    .m_axi_rready_o    (rready),
    .m_axi_rdata_i     (rdata),
    .m_axi_rlast_i     (rlast)
  );

  tb_axi_mem axi_mem_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .arvalid_i (arvalid),
    .arready_o (arready),
    .araddr_i  (araddr),
    .arlen_i   (arlen),
    .rvalid_o  (rvalid),
    .rready_i  (rready),
    .rdata_o   (rdata),
    .rlast_o   (rlast)
  );

  initial begin : clock_gen
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ============================================================
  // reporting helpers
  // ============================================================
  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
    errors++;
  endtask

  task automatic report_problem(input string msg);
    $display("ERROR at %0t: %s", $time, msg);
    errors++;
  endtask

  task automatic finish_test(input string name, input int errors_before);
    n_tests++;
    if (errors == errors_before) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, errors - errors_before);
    end
  endtask

  // ============================================================
  // reference model run once per accepted request in order
  // ============================================================
  task automatic model_lookup(input addr_t a);
    index_t s;
    tag_t   t;
    int     way;
    s   = index_t'(a / LINE_BYTES);
    t   = tag_t'(a / (LINE_BYTES * SETS));
    way = -1;
    for (int w = 0; w < WAYS; w++) begin
      if (m_valid[s][w] && m_tag[s][w] == t) way = w;
    end
    if (way < 0) begin
      // fill the way the replacement bit names
      way          = int'(m_lru[s]);
      m_valid[s][way] = 1'b1;
      m_tag[s][way]   = t;
      ar_q.push_back(a & ~addr_t'(LINE_BYTES - 1));
      n_miss++;
    end else begin
      expect_valid = 1'b1;
    end
    if (int'(m_lru[s]) == way) m_lru[s] = ~m_lru[s];
    rsp_q.push_back(a);
  endtask

  // samples at the rising edge before any register update
  always @(posedge clk) begin : monitor
    addr_t exp_addr;
    if (rst_n) begin
      if (expect_valid && !fetch_rsp_valid_o) begin
        report_mismatch("fetch_rsp_valid_o after hit", 32'(fetch_rsp_valid_o), 32'd1);
      end
      expect_valid = 1'b0;
      if (prev_stall) begin
        if (!fetch_rsp_valid_o) report_mismatch("fetch_rsp_valid_o", 32'd0, 32'd1);
        if (fetch_rsp_addr_o != prev_addr) begin
          report_mismatch("fetch_rsp_addr_o", fetch_rsp_addr_o, prev_addr);
        end
        if (fetch_rsp_instr_o != prev_instr) begin
          report_mismatch("fetch_rsp_instr_o", fetch_rsp_instr_o, prev_instr);
        end
      end
      prev_stall = fetch_rsp_valid_o && !fetch_rsp_ready_i;
      prev_addr  = fetch_rsp_addr_o;
      prev_instr = fetch_rsp_instr_o;
      if (fetch_rsp_valid_o && fetch_rsp_ready_i) begin
        n_rsp++;
        if (rsp_q.size() == 0) begin
          report_problem("response with no request outstanding");
        end else begin
          exp_addr = rsp_q.pop_front();
          if (fetch_rsp_addr_o != exp_addr) begin
            report_mismatch("fetch_rsp_addr_o", fetch_rsp_addr_o, exp_addr);
          end
          if (fetch_rsp_instr_o != mix_word(exp_addr)) begin
            report_mismatch("fetch_rsp_instr_o", fetch_rsp_instr_o, mix_word(exp_addr));
          end
        end
      end
      if (arvalid && arready) begin
        n_ar++;
        if (ar_q.size() == 0) begin
          report_problem("AR issued although the model predicts a hit");
        end else begin
          exp_addr = ar_q.pop_front();
          if (araddr != exp_addr) report_mismatch("m_axi_araddr_o", araddr, exp_addr);
        end
        if (arlen != 8'd3) report_mismatch("m_axi_arlen_o", 32'(arlen), 32'd3);
        if (arsize != 3'd2) report_mismatch("m_axi_arsize_o", 32'(arsize), 32'd2);
        if (arburst != 2'b01) report_mismatch("m_axi_arburst_o", 32'(arburst), 32'd1);
      end
      if (fetch_req_valid_i && fetch_req_ready_o) model_lookup(fetch_addr_i);
    end
  end

  // ============================================================
  // stimulus
  // ============================================================
  function automatic addr_t random_addr();
    tag_t      t;
    index_t    s;
    word_sel_t w;
    t = tag_t'($urandom_range(3));
    s = index_t'($urandom_range(3) * 5);
    w = word_sel_t'($urandom_range(3));
    return {t, s, w, 2'b00};
  endfunction

  task automatic send_fetch(input addr_t a);
    logic accepted;
    int   cycles;
    cycles            = 0;
    fetch_req_valid_i = 1'b1;
    fetch_addr_i      = a;
    do begin
      fetch_rsp_ready_i = ($urandom_range(3) != 0);
      @(posedge clk);
      accepted = fetch_req_ready_o;
      @(negedge clk);
      cycles++;
    end while (!accepted && cycles < ACCEPT_TIMEOUT);
    fetch_req_valid_i = 1'b0;
    if (!accepted) report_problem("timeout waiting for fetch_req_ready_o");
  endtask

  task automatic drain_responses();
    int cycles;
    cycles = 0;
    while (rsp_q.size() != 0 && cycles < DRAIN_TIMEOUT) begin
      fetch_rsp_ready_i = ($urandom_range(3) != 0);
      @(negedge clk);
      cycles++;
    end
    fetch_rsp_ready_i = 1'b1;
    if (rsp_q.size() != 0) report_problem("timeout waiting for outstanding responses");
    if (ar_q.size() != 0) report_problem("model misses left without an AR");
  endtask

  initial begin : main
    int errs_before;
    int ar_before;
    int miss_before;
    void'($urandom(32'h037fbfab));
    rst_n             = 1'b0;
    fetch_req_valid_i = 1'b0;
    fetch_addr_i      = '0;
    fetch_rsp_ready_i = 1'b1;
    expect_valid      = 1'b0;
    prev_stall        = 1'b0;
    errors            = 0;
    n_tests           = 0;
    n_rsp             = 0;
    n_ar              = 0;
    n_miss            = 0;
    for (int s = 0; s < SETS; s++) begin
      m_lru[s] = 1'b0;
      for (int w = 0; w < WAYS; w++) begin
        m_valid[s][w] = 1'b0;
        m_tag[s][w]   = '0;
      end
    end
    repeat (16) @(negedge clk);
    rst_n = 1'b1;

    errs_before = errors;
    if (fetch_rsp_valid_o) report_mismatch("fetch_rsp_valid_o", 32'd1, 32'd0);
    if (arvalid) report_mismatch("m_axi_arvalid_o", 32'd1, 32'd0);
    if (rready) report_mismatch("m_axi_rready_o", 32'd1, 32'd0);
    finish_test("reset_outputs", errs_before);

    errs_before = errors;
    for (int i = 0; i < N_RANDOM; i++) begin
      send_fetch(random_addr());
    end
    drain_responses();
    finish_test("random_fetch", errs_before);

    // three tags fighting over two ways of one set
    errs_before = errors;
    ar_before   = n_ar;
    miss_before = n_miss;
    for (int i = 0; i < 10; i++) begin
      send_fetch({tag_t'(23'h100 + PATTERN[i]), index_t'(20), word_sel_t'(i % 4), 2'b00});
    end
    drain_responses();
    if (n_ar - ar_before != n_miss - miss_before) begin
      report_mismatch("m_axi_arvalid_o handshakes", 32'(n_ar - ar_before),
                      32'(n_miss - miss_before));
    end
    finish_test("set_conflict", errs_before);

    $display("tests %0d, responses %0d, ARs %0d, errors %0d", n_tests, n_rsp, n_ar, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* verif/tb_axi_mem.sv */
// AXI4 read-burst responder for INCR bursts of 4-byte beats; one burst at a time, never errors
`timescale 1ns/1ps

module tb_axi_mem (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        arvalid_i,
  output logic        arready_o,
  input  logic [31:0] araddr_i,
  input  logic [7:0]  arlen_i,
  output logic        rvalid_o,
  input  logic        rready_i,
  output logic [31:0] rdata_o,
  output logic        rlast_o
);

  `include "tb_mix.svh"

  initial begin : serve_bursts
    logic [31:0] beat_addr;
    int          beats;
    int          wait_cnt;
    arready_o = 1'b0;
    rvalid_o  = 1'b0;
    rdata_o   = '0;
    rlast_o   = 1'b0;
    forever begin
      @(negedge clk);
      if (rst_n && arvalid_i) begin
        // random address accept delay
        repeat ($urandom_range(3)) @(negedge clk);
        arready_o = 1'b1;
        beat_addr = araddr_i;
        beats     = int'(arlen_i) + 1;
        @(negedge clk);
        arready_o = 1'b0;
        for (int b = 0; b < beats; b++) begin
          repeat ($urandom_range(2)) @(negedge clk);
          rvalid_o = 1'b1;
          rdata_o  = mix_word(beat_addr);
          rlast_o  = (b == beats - 1);
          wait_cnt = 0;
          @(posedge clk);
          while (!rready_i && wait_cnt < 64) begin
            wait_cnt++;
            @(posedge clk);
          end
          @(negedge clk);
          rvalid_o  = 1'b0;
          rlast_o   = 1'b0;
          beat_addr = beat_addr + 32'd4;
        end
      end
    end
  end

endmodule

/* hdl/icache_top.sv */
// 2-way 1 KiB instruction cache; single outstanding AXI4 INCR read burst, no write channels
`timescale 1ns/1ps

module icache_top (
  input  logic                   clk,
  input  logic                   rst_n,

  // fetch request
  input  logic                   fetch_req_valid_i,
  output logic                   fetch_req_ready_o,
  input  icache_pkg::addr_t      fetch_addr_i,

  // fetch response
  output logic                   fetch_rsp_valid_o,
  input  logic                   fetch_rsp_ready_i,
  output icache_pkg::addr_t      fetch_rsp_addr_o,
  output icache_pkg::word_t      fetch_rsp_instr_o,

  // axi read address
  output logic                   m_axi_arvalid_o,
  input  logic                   m_axi_arready_i,
  output icache_pkg::addr_t      m_axi_araddr_o,
  output logic [7:0]             m_axi_arlen_o,
  output logic [2:0]             m_axi_arsize_o,
  output logic [1:0]             m_axi_arburst_o,

  // axi read data
  input  logic                   m_axi_rvalid_i,
  output logic                   m_axi_rready_o,
  input  icache_pkg::word_t      m_axi_rdata_i,
  input  logic                   m_axi_rlast_i
);

  icache_array_if  arr_if ();
  icache_refill_if rfl_if ();

  icache_pipeline icache_pipeline_i (
    .clk               (clk),
    .rst_n             (rst_n),
    .fetch_req_valid_i (fetch_req_valid_i),
    .fetch_req_ready_o (fetch_req_ready_o),
    .fetch_addr_i      (fetch_addr_i),
    .fetch_rsp_valid_o (fetch_rsp_valid_o),
    .fetch_rsp_ready_i (fetch_rsp_ready_i),
    .fetch_rsp_addr_o  (fetch_rsp_addr_o),
    .fetch_rsp_instr_o (fetch_rsp_instr_o),
    .arr               (arr_if.pipe),
    .rfl               (rfl_if.pipe)
  );

  icache_refill icache_refill_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .rfl             (rfl_if.refill),
    .m_axi_arvalid_o (m_axi_arvalid_o),
    .m_axi_arready_i (m_axi_arready_i),
    .m_axi_araddr_o  (m_axi_araddr_o),
    .m_axi_arlen_o   (m_axi_arlen_o),
    .m_axi_arsize_o  (m_axi_arsize_o),
    .m_axi_arburst_o (m_axi_arburst_o),
    .m_axi_rvalid_i  (m_axi_rvalid_i),
    .m_axi_rready_o  (m_axi_rready_o),
    .m_axi_rdata_i   (m_axi_rdata_i),
    .m_axi_rlast_i   (m_axi_rlast_i)
  );

  icache_arrays icache_arrays_i (
    .clk   (clk),
    .rst_n (rst_n),
    .arr   (arr_if.arrays)
  );

endmodule

/* icache/icache_refill.sv */
// one line refill at a time; expects a full 4-beat INCR burst with rlast on the last beat
`timescale 1ns/1ps

module icache_refill (
  input  logic                   clk,
  input  logic                   rst_n,
  icache_refill_if.refill        rfl,
  output logic                   m_axi_arvalid_o,
  input  logic                   m_axi_arready_i,
  output icache_pkg::addr_t      m_axi_araddr_o,
  output logic [7:0]             m_axi_arlen_o,
  output logic [2:0]             m_axi_arsize_o,
  output logic [1:0]             m_axi_arburst_o,
  input  logic                   m_axi_rvalid_i,
  output logic                   m_axi_rready_o,
  input  icache_pkg::word_t      m_axi_rdata_i,
  input  logic                   m_axi_rlast_i
);
  import icache_pkg::*;

  localparam word_sel_t LAST_BEAT = word_sel_t'(WORDS_PER_LINE - 1);

  refill_state_t  state_q;
  word_sel_t      beat_cnt_q;
  word_t          buf_q [WORDS_PER_LINE-1];
  logic           beat;

  // ============================================================
  // miss FSM
  // ============================================================
  assign beat = (state_q == REFILL_DATA) && m_axi_rvalid_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q    <= REFILL_IDLE;
      beat_cnt_q <= '0;
    end else begin
      case (state_q)
        REFILL_IDLE: if (rfl.req) state_q <= REFILL_ADDR;
        REFILL_ADDR: if (m_axi_arready_i) state_q <= REFILL_DATA;
        REFILL_DATA: begin
          if (m_axi_rvalid_i) begin
            beat_cnt_q <= beat_cnt_q + 1'b1;
            if (m_axi_rlast_i) begin
              state_q    <= REFILL_IDLE;
              beat_cnt_q <= '0;
            end
          end
        end
        default: state_q <= REFILL_IDLE;
      endcase
    end
  end

  // AR/R drive
  assign m_axi_arvalid_o = (state_q == REFILL_ADDR);
  assign m_axi_araddr_o  = rfl.addr;
  assign m_axi_arlen_o   = BURST_LEN;
  assign m_axi_arsize_o  = BURST_SIZE;
  // INCR
  assign m_axi_arburst_o = 2'b01;
  assign m_axi_rready_o  = (state_q == REFILL_DATA);

  // ============================================================
  // line assembly
  // ============================================================
  always_ff @(posedge clk) begin
    if (beat && beat_cnt_q != LAST_BEAT) begin
      buf_q[beat_cnt_q] <= m_axi_rdata_i;
    end
  end

  // last beat goes straight into the line
  always_comb begin
    for (int i = 0; i < WORDS_PER_LINE - 1; i++) begin
      rfl.line[i*$bits(word_t) +: $bits(word_t)] = buf_q[i];
    end
    rfl.line[(WORDS_PER_LINE-1)*$bits(word_t) +: $bits(word_t)] = m_axi_rdata_i;
  end

  assign rfl.done = beat && m_axi_rlast_i;

  a_rlast_on_last_beat: assert property (@(posedge clk) disable iff (!rst_n)
    beat |-> (m_axi_rlast_i == (beat_cnt_q == LAST_BEAT)));

  a_ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
    m_axi_arvalid_o && !m_axi_arready_i |=> m_axi_arvalid_o && $stable(m_axi_araddr_o));

endmodule

/* icache/icache_pipeline.sv */
// two-stage lookup; a hit answers one cycle after accept, a miss stalls stage 1 until refill done
`timescale 1ns/1ps

module icache_pipeline (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   fetch_req_valid_i,
  output logic                   fetch_req_ready_o,
  input  icache_pkg::addr_t      fetch_addr_i,
  output logic                   fetch_rsp_valid_o,
  input  logic                   fetch_rsp_ready_i,
  output icache_pkg::addr_t      fetch_rsp_addr_o,
  output icache_pkg::word_t      fetch_rsp_instr_o,
  icache_array_if.pipe           arr,
  icache_refill_if.pipe          rfl
);
  import icache_pkg::*;

  logic               s1_valid;
  addr_t              s1_addr;
  tag_t               s1_tag;
  index_t             s1_index;
  word_sel_t          s1_word;
  logic [WAYS-1:0]    hit_oh;
  logic               hit;
  way_t               hit_way;
  line_t              hit_line;

  // ============================================================
  // stage 0 accepts and addresses the arrays
  // ============================================================
  assign fetch_req_ready_o = !s1_valid || (hit && fetch_rsp_ready_i);

  // stalled stage 1 keeps rereading its own set
  assign arr.rd_index = fetch_req_ready_o ? fetch_addr_i[OFFSET_W +: INDEX_W] : s1_index;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
    end else if (fetch_req_ready_o) begin
      s1_valid <= fetch_req_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (fetch_req_ready_o && fetch_req_valid_i) begin
      s1_addr <= fetch_addr_i;
    end
  end

  // ============================================================
  // stage 1 compares tags and responds
  // ============================================================
  assign s1_tag   = s1_addr[ADDR_W-1 -: TAG_W];
  assign s1_index = s1_addr[OFFSET_W +: INDEX_W];
  assign s1_word  = s1_addr[2 +: $bits(word_sel_t)];

  always_comb begin
    hit_way = '0;
    for (int w = 0; w < WAYS; w++) begin
      hit_oh[w] = arr.rd_valid[w] && (arr.rd_tag[w] == s1_tag);
      if (hit_oh[w]) begin
        hit_way = way_t'(w);
      end
    end
  end

  assign hit      = |hit_oh;
  assign hit_line = arr.rd_line[hit_way];

  assign fetch_rsp_valid_o = s1_valid && hit;
  assign fetch_rsp_addr_o  = s1_addr;
  assign fetch_rsp_instr_o = hit_line[s1_word * $bits(word_t) +: $bits(word_t)];

  // replacement bit moves away from the way just used once per completed hit
  assign arr.lru_wr_en  = fetch_rsp_valid_o && fetch_rsp_ready_i;
  assign arr.lru_wr_bit = (arr.rd_lru == hit_way) ? ~arr.rd_lru : arr.rd_lru;

  // ============================================================
  // miss handling
  // ============================================================
  assign rfl.req  = s1_valid && !hit;
  assign rfl.addr = {s1_addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};

  // victim is the way the replacement bit names
  always_comb begin
    for (int w = 0; w < WAYS; w++) begin
      arr.wr_en[w] = rfl.done && (arr.rd_lru == way_t'(w));
    end
  end

  assign arr.wr_index = s1_index;
  assign arr.wr_tag   = s1_tag;
  assign arr.wr_line  = rfl.line;

  // a refilled line only lands while stage 1 is waiting on its miss
  a_wr_on_miss: assert property (@(posedge clk) disable iff (!rst_n)
    |arr.wr_en |-> rfl.req);

  // the re-lookup after a refill hits through the array forwarding, so no second req
  a_refill_hits: assert property (@(posedge clk) disable iff (!rst_n)
    rfl.done |=> s1_valid && hit && !rfl.req);

endmodule

/* icache/icache_arrays.sv */
// valid and replacement bits reset to zero, so a cold cache misses without RAM init
`timescale 1ns/1ps

module icache_arrays (
  input  logic             clk,
  input  logic             rst_n,
  icache_array_if.arrays   arr
);
  import icache_pkg::*;

  line_t [WAYS-1:0]   tag_raw;
  logic  [WAYS-1:0]   valid_q [SETS];
  way_t               lru_q [SETS];
  logic  [WAYS-1:0]   rd_valid_q;
  way_t               rd_lru_q;

  // ============================================================
  // per-way tag and data RAMs
  // ============================================================
  for (genvar w = 0; w < WAYS; w++) begin : g_way
    // tag occupies the low bits of the ram word
    icache_sdp_ram tag_ram_i (
      .clk     (clk),
      .we_i    (arr.wr_en[w]),
      .waddr_i (arr.wr_index),
      .wdata_i (line_t'(arr.wr_tag)),
      .raddr_i (arr.rd_index),
      .rdata_o (tag_raw[w])
    );

    icache_sdp_ram data_ram_i (
      .clk     (clk),
      .we_i    (arr.wr_en[w]),
      .waddr_i (arr.wr_index),
      .wdata_i (arr.wr_line),
      .raddr_i (arr.rd_index),
      .rdata_o (arr.rd_line[w])
    );

    assign arr.rd_tag[w] = tag_raw[w][TAG_W-1:0];
  end

  // ============================================================
  // valid and replacement bits read write-first like the RAMs
  // ============================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q    <= '{default: '0};
      lru_q      <= '{default: '0};
      rd_valid_q <= '0;
      rd_lru_q   <= '0;
    end else begin
      for (int w = 0; w < WAYS; w++) begin
        if (arr.wr_en[w]) valid_q[arr.wr_index][w] <= 1'b1;
        rd_valid_q[w] <= valid_q[arr.rd_index][w] ||
                         (arr.wr_en[w] && arr.wr_index == arr.rd_index);
      end
      if (arr.lru_wr_en) lru_q[arr.wr_index] <= arr.lru_wr_bit;
      rd_lru_q <= (arr.lru_wr_en && arr.wr_index == arr.rd_index) ? arr.lru_wr_bit
                                                                  : lru_q[arr.rd_index];
    end
  end

  assign arr.rd_valid = rd_valid_q;
  assign arr.rd_lru   = rd_lru_q;

endmodule

/* icache/icache_sdp_ram.sv */
// line-wide storage, registered write-first read, no reset so contents are unknown after power-up
`timescale 1ns/1ps

module icache_sdp_ram (
  input  logic                   clk,
  input  logic                   we_i,
  input  icache_pkg::index_t     waddr_i,
  input  icache_pkg::line_t      wdata_i,
  input  icache_pkg::index_t     raddr_i,
  output icache_pkg::line_t      rdata_o
);
  import icache_pkg::*;

  line_t mem_q [SETS];

  always_ff @(posedge clk) begin
    if (we_i) begin
      mem_q[waddr_i] <= wdata_i;
    end
  end

  // a write to the address being read is forwarded to the read port
  always_ff @(posedge clk) begin
    if (we_i && waddr_i == raddr_i) begin
      rdata_o <= wdata_i;
    end else begin
      rdata_o <= mem_q[raddr_i];
    end
  end

endmodule

/* common/icache_refill_if.sv */
// req is a level held with a line-aligned addr until the one-cycle done pulse
`timescale 1ns/1ps

interface icache_refill_if;
  import icache_pkg::*;

  // pipeline to refill engine
  logic   req;
  addr_t  addr;

  // refill engine to pipeline
  logic   done;
  // only meaningful while done is high
  line_t  line;

  modport pipe (
    output req, addr,
    input  done, line
  );

  modport refill (
    input  req, addr,
    output done, line
  );

endinterface

/* common/icache_array_if.sv */
// array reads return one cycle after rd_index; a same-cycle write to the read index is forwarded
`timescale 1ns/1ps

interface icache_array_if;
  import icache_pkg::*;

  // read side
  index_t               rd_index;
  tag_t   [WAYS-1:0]    rd_tag;
  logic   [WAYS-1:0]    rd_valid;
  line_t  [WAYS-1:0]    rd_line;
  way_t                 rd_lru;

  // one-hot per-way refill write
  logic   [WAYS-1:0]    wr_en;
  index_t               wr_index;
  tag_t                 wr_tag;
  line_t                wr_line;

  // replacement bit update sharing wr_index
  logic                 lru_wr_en;
  way_t                 lru_wr_bit;

  modport pipe (
    output rd_index, wr_en, wr_index, wr_tag, wr_line, lru_wr_en, lru_wr_bit,
    input  rd_tag, rd_valid, rd_line, rd_lru
  );

  modport arrays (
    input  rd_index, wr_en, wr_index, wr_tag, wr_line, lru_wr_en, lru_wr_bit,
    output rd_tag, rd_valid, rd_line, rd_lru
  );

endinterface

/* common/icache_pkg.sv */
// geometry is fixed here; addresses are byte addresses and every fetch is word-aligned
package icache_pkg;

  // ============================================================
  // geometry
  // ============================================================
  localparam int ADDR_W         = 32;
  localparam int CACHE_BYTES    = 1024;
  localparam int LINE_BYTES     = 16;
  localparam int WAYS           = 2;
  localparam int WORDS_PER_LINE = LINE_BYTES / 4;
  localparam int SETS           = CACHE_BYTES / (LINE_BYTES * WAYS);
  localparam int OFFSET_W       = $clog2(LINE_BYTES);
  localparam int INDEX_W        = $clog2(SETS);
  localparam int TAG_W          = ADDR_W - INDEX_W - OFFSET_W;

  // axi burst codes for one line refill
  localparam logic [7:0] BURST_LEN  = 8'(WORDS_PER_LINE - 1);
  localparam logic [2:0] BURST_SIZE = 3'b010;

  // ============================================================
  // types
  // ============================================================
  typedef logic [ADDR_W-1:0]                    addr_t;
  typedef logic [31:0]                          word_t;
  typedef logic [TAG_W-1:0]                     tag_t;
  typedef logic [INDEX_W-1:0]                   index_t;
  typedef logic [$clog2(WORDS_PER_LINE)-1:0]    word_sel_t;
  // word 0 in the low bits
  typedef logic [LINE_BYTES*8-1:0]              line_t;
  typedef logic [$clog2(WAYS)-1:0]              way_t;

  typedef enum logic [1:0] {
    REFILL_IDLE,
    REFILL_ADDR,
    REFILL_DATA
  } refill_state_t;

endpackage
